// File: sources.f
+incdir+hw
hw/ex_pkg.sv
hw/ex_stage.sv
hw/ex_alu.sv
hw/ex_mem_req.sv
hw/ex_top.sv
tb/tb_ex_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_ex_top.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module tb_ex_top;
    import ex_pkg::*;

    localparam int PERIOD = 100;
    localparam int K_ALU  = 0;
    localparam int K_LD   = 1;
    localparam int K_ST   = 2;

    typedef struct {
        alu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rkd;
        int          kind;    // plain op, load or store
        ls_size_e    size;
        bit          mexc;
        bit          wexc;
        bit          kill;    // flushed while in EX
    } entry_t;

    logic       clk;
    logic       resetn;
    logic       flush;
    logic       in_valid;
    logic       ex_allowin;
    logic       mem_allowin;
    logic       ex_to_mem_valid;
    logic       mem_excep;
    logic       wb_excep;
    id_to_ex_t  id_to_ex;
    ex_to_mem_t ex_to_mem;
    ex_fwd_t    ex_fwd;
    sram_req_t  data_sram;

    entry_t     tab[$];
    int         seed = 2589;
    int         idx;           // next entry to offer
    int         cur;           // entry held in EX, -1 when empty
    int         cyc;           // cycles spent in EX
    bit         offering;
    bit         kill_now;
    bit         held_ok;
    ex_to_mem_t held;

    ex_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    // budget per entry covers a full multiply plus stalls
    initial begin
        #1;
        #((tab.size() * (`EX_MUL_ITER + 10) + 10) * PERIOD);
        $display("watchdog expired before all table entries finished");
        $display("TEST FAIL");
        $fatal(1, "timeout");
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic add(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                       input logic [31:0] rkd, input int kind, input ls_size_e size,
                       input bit mexc, input bit wexc, input bit kill);
        entry_t e;
        e.op   = op;
        e.a    = a;
        e.b    = b;
        e.rkd  = rkd;
        e.kind = kind;
        e.size = size;
        e.mexc = mexc;
        e.wexc = wexc;
        e.kill = kill;
        tab.push_back(e);
    endtask

    task automatic load_table();
        add(ALU_ADD,   32'h0000_0005, 32'h0000_0007, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_ADD,   32'hffff_ffff, 32'h0000_0001, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_SUB,   32'h0000_0003, 32'h0000_000a, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_SLT,   32'hffff_fff0, 32'h0000_0005, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_SLTU,  32'hffff_fff0, 32'h0000_0005, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_AND,   32'hf0f0_1234, 32'h0ff0_ff00, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_OR,    32'hf0f0_1234, 32'h0ff0_ff00, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_NOR,   32'hf0f0_1234, 32'h0ff0_ff00, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_XOR,   32'hf0f0_1234, 32'h0ff0_ff00, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_SLL,   32'h0000_0001, 32'h0000_0023, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_SRL,   32'h8000_0010, 32'h0000_0004, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_SRA,   32'h8000_0010, 32'h0000_0004, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_LUI,   32'h0000_0000, 32'habcd_e000, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_MUL,   32'h1234_5678, 32'h9abc_def0, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_MULH,  32'hffff_fff9, 32'h0000_0003, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_MULH,  32'h8000_0000, 32'h8000_0000, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_MULHU, 32'hffff_ffff, 32'hffff_ffff, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_MUL,   32'hffff_fffe, 32'h0000_0005, 0, K_ALU, LS_W, 0, 0, 0);
        // byte and half stores at every lane
        add(ALU_ADD, 32'h0000_1000, 32'h0, 32'ha1b2_c3d4, K_ST, LS_B, 0, 0, 0);
        add(ALU_ADD, 32'h0000_1000, 32'h1, 32'ha1b2_c3d4, K_ST, LS_B, 0, 0, 0);
        add(ALU_ADD, 32'h0000_1000, 32'h2, 32'ha1b2_c3d4, K_ST, LS_B, 0, 0, 0);
        add(ALU_ADD, 32'h0000_1000, 32'h3, 32'ha1b2_c3d4, K_ST, LS_B, 0, 0, 0);
        add(ALU_ADD, 32'h0000_2000, 32'h0, 32'h5566_7788, K_ST, LS_H, 0, 0, 0);
        add(ALU_ADD, 32'h0000_2000, 32'h2, 32'h5566_7788, K_ST, LS_H, 0, 0, 0);
        add(ALU_ADD, 32'h0000_3000, 32'h0, 32'hdead_beef, K_ST, LS_W, 0, 0, 0);
        add(ALU_ADD, 32'h0000_3000, 32'h4, 32'h0,         K_LD, LS_W, 0, 0, 0);
        add(ALU_ADD, 32'h0000_3000, 32'h7, 32'h0,         K_LD, LS_B, 0, 0, 0);
        add(ALU_ADD, 32'h0000_3000, 32'ha, 32'h0,         K_LD, LS_H, 0, 0, 0);
        // misaligned accesses
        add(ALU_ADD, 32'h0000_1000, 32'h1, 32'h1122_3344, K_ST, LS_H, 0, 0, 0);
        add(ALU_ADD, 32'h0000_1000, 32'h2, 32'h0,         K_LD, LS_W, 0, 0, 0);
        add(ALU_ADD, 32'h0000_1000, 32'h3, 32'h1122_3344, K_ST, LS_W, 0, 0, 0);
        add(ALU_ADD, 32'h0000_1000, 32'h3, 32'h0,         K_LD, LS_H, 0, 0, 0);
        // older exceptions in mem or wb
        add(ALU_ADD, 32'h0000_4000, 32'h0, 32'hcafe_f00d, K_ST, LS_W, 1, 0, 0);
        add(ALU_ADD, 32'h0000_4000, 32'h1, 32'h0,         K_LD, LS_B, 0, 1, 0);
        add(ALU_ADD, 32'h0000_4000, 32'h2, 32'h0000_0099, K_ST, LS_B, 1, 1, 0);
        // flushed multiplies, each followed by a normal op
        add(ALU_MUL,   32'h0000_1111, 32'h0000_2222, 0, K_ALU, LS_W, 0, 0, 1);
        add(ALU_ADD,   32'h0000_0100, 32'h0000_0023, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_MULHU, 32'h8765_4321, 32'h1234_5678, 0, K_ALU, LS_W, 0, 0, 1);
        add(ALU_MULH,  32'h7fff_ffff, 32'h8000_0001, 0, K_ALU, LS_W, 0, 0, 0);
        add(ALU_SUB,   32'h0000_0000, 32'h0000_0001, 0, K_ALU, LS_W, 0, 0, 0);
    endtask

    function automatic logic [31:0] ref_alu(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [63:0] p_s;
        logic [63:0] p_u;
        p_s = {{32{a[31]}}, a} * {{32{b[31]}}, b};  // low 64 bits of signed product
        p_u = {32'h0, a} * {32'h0, b};
        case (op)
            ALU_ADD:   return a + b;
            ALU_SUB:   return a - b;
            ALU_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:   return a & b;
            ALU_OR:    return a | b;
            ALU_NOR:   return ~(a | b);
            ALU_XOR:   return a ^ b;
            ALU_SLL:   return a << b[4:0];
            ALU_SRL:   return a >> b[4:0];
            ALU_SRA:   return $signed(a) >>> b[4:0];
            ALU_LUI:   return b;
            ALU_MUL:   return p_u[31:0];
            ALU_MULH:  return p_s[63:32];
            ALU_MULHU: return p_u[63:32];
            default:   return 32'h0;
        endcase
    endfunction

    function automatic logic exp_ale(input entry_t e, input logic [31:0] addr);
        return (e.kind != K_ALU) &&
               ((e.size == LS_H && addr[0]) || (e.size == LS_W && addr[1:0] != 2'b00));
    endfunction

    function automatic logic [3:0] exp_we(input entry_t e, input logic [31:0] addr);
        logic [3:0] m;
        int         n;
        int         lo;
        int         k;
        n  = (e.size == LS_B) ? 1 : (e.size == LS_H) ? 2 : 4;  // bytes per access
        lo = int'(addr[1:0]);
        m  = 4'b0000;
        for (k = 0; k < 4; k++) begin
            if (k / n == lo / n)
                m[k] = 1'b1;  // lane inside the addressed group
        end
        return (e.kind == K_ST) ? m : 4'b0000;
    endfunction

    function automatic logic [31:0] exp_wdata(input entry_t e);
        case (e.size)
            LS_B:    return {4{e.rkd[7:0]}};
            LS_H:    return {2{e.rkd[15:0]}};
            default: return e.rkd;
        endcase
    endfunction

    function automatic id_to_ex_t make_inst(input int i);
        id_to_ex_t d;
        d              = '0;
        d.pc           = 32'h1c00_0000 + 32'(i * 4);
        d.alu_op       = tab[i].op;
        d.src1         = tab[i].a;
        d.src2         = tab[i].b;
        d.rkd_value    = tab[i].rkd;
        d.res_from_mem = (tab[i].kind == K_LD);
        d.mem_we       = (tab[i].kind == K_ST);
        d.rf_we        = (tab[i].kind != K_ST);
        d.rf_waddr     = i[4:0];
        d.ls_size      = tab[i].size;
        d.ls_unsigned  = i[0];
        d.csr_re       = i[1];
        d.csr_we       = i[2];
        d.csr_num      = 14'(i * 37 + 3);
        d.csr_wmask    = 32'h0f0f_0000 ^ 32'(i * 9);
        d.ertn         = (i % 7 == 4);
        d.id_excep_en  = (i % 5 == 2);  // exception raised before EX
        d.excep        = excep_t'(13'(i * 211 + 1));
        return d;
    endfunction

    task automatic drive_cycle();
        if (!offering && idx < tab.size() && ($random(seed) & 3) != 0) begin
            offering = 1'b1;           // held until accepted
            id_to_ex = make_inst(idx);
        end
        kill_now    = (cur >= 0) && tab[cur].kill && (cyc == 5);
        flush       = kill_now;
        in_valid    = offering && !kill_now;
        mem_allowin = ($random(seed) & 3) != 0;
        mem_excep   = (cur >= 0) ? tab[cur].mexc : 1'b0;
        wb_excep    = (cur >= 0) ? tab[cur].wexc : 1'b0;
    endtask

    task automatic check_outputs();
        entry_t      e;
        id_to_ex_t   d;
        logic [31:0] res;
        logic        ale;
        if (cur < 0) begin
            check("ex_to_mem_valid", ex_to_mem_valid, 0);
            check("ex_allowin", ex_allowin, 1);
            check("ex_fwd.rf_we", ex_fwd.rf_we, 0);
            check("ex_fwd.res_from_mem", ex_fwd.res_from_mem, 0);
            check("ex_fwd.csr_re", ex_fwd.csr_re, 0);
            check("data_sram.en", data_sram.en, 0);
            check("data_sram.we", data_sram.we, 0);
        end else begin
            e   = tab[cur];
            d   = make_inst(cur);
            res = ref_alu(e.op, e.a, e.b);
            ale = exp_ale(e, res);
            check("ex_allowin", ex_allowin, ex_to_mem_valid & mem_allowin);
            check("ex_fwd.rf_we", ex_fwd.rf_we, e.kind != K_ST);
            check("ex_fwd.res_from_mem", ex_fwd.res_from_mem, e.kind == K_LD);
            check("ex_fwd.rf_waddr", ex_fwd.rf_waddr, cur[4:0]);
            check("ex_fwd.csr_re", ex_fwd.csr_re, d.csr_re);
            check("data_sram.en", data_sram.en,
                  e.kind != K_ALU && !ale && !e.mexc && !e.wexc);
            check("data_sram.we", data_sram.we, exp_we(e, res));
            if (!(e.op inside {ALU_MUL, ALU_MULH, ALU_MULHU}))
                check("ex_to_mem_valid", ex_to_mem_valid, 1);  // one edge latency
            if (kill_now)
                check("ex_to_mem_valid", ex_to_mem_valid, 0);
            if (ex_to_mem_valid) begin
                check("ex_to_mem.alu_result", ex_to_mem.alu_result, res);
                check("ex_fwd.alu_result", ex_fwd.alu_result, res);
                check("ex_to_mem.pc", ex_to_mem.pc, 32'h1c00_0000 + 32'(cur * 4));
                check("ex_to_mem.rf_we", ex_to_mem.rf_we, e.kind != K_ST);
                check("ex_to_mem.rf_waddr", ex_to_mem.rf_waddr, cur[4:0]);
                check("ex_to_mem.res_from_mem", ex_to_mem.res_from_mem, e.kind == K_LD);
                check("ex_to_mem.addr_lo", ex_to_mem.addr_lo, res[1:0]);
                check("ex_to_mem.ls_size", ex_to_mem.ls_size, e.size);
                check("ex_to_mem.ls_unsigned", ex_to_mem.ls_unsigned, d.ls_unsigned);
                check("ex_to_mem.rkd_value", ex_to_mem.rkd_value, e.rkd);
                check("ex_to_mem.csr_re", ex_to_mem.csr_re, d.csr_re);
                check("ex_to_mem.csr_we", ex_to_mem.csr_we, d.csr_we);
                check("ex_to_mem.csr_num", ex_to_mem.csr_num, d.csr_num);
                check("ex_to_mem.csr_wmask", ex_to_mem.csr_wmask, d.csr_wmask);
                check("ex_to_mem.ertn", ex_to_mem.ertn, d.ertn);
                check("ex_to_mem.excep", ex_to_mem.excep, d.excep);
                check("ex_to_mem.ale", ex_to_mem.ale, ale);
                check("ex_to_mem.excep_en", ex_to_mem.excep_en, ale | d.id_excep_en);
                check("data_sram.addr", data_sram.addr, res);
                if (e.kind == K_ST)
                    check("data_sram.wdata", data_sram.wdata, exp_wdata(e));
            end
        end
        if (held_ok)
            check("ex_to_mem held stable", ex_to_mem === held, 1);
    endtask

    task automatic advance();
        held_ok = (cur >= 0) && ex_to_mem_valid && !mem_allowin;
        held    = ex_to_mem;
        if (kill_now) begin
            cur = -1;                  // killed, never leaves EX
        end else begin
            if (cur >= 0 && ex_to_mem_valid && mem_allowin)
                cur = -1;
            if (in_valid && ex_allowin) begin
                cur      = idx;
                idx      = idx + 1;
                offering = 1'b0;
                cyc      = 0;
            end else if (cur >= 0) begin
                cyc = cyc + 1;
            end
        end
    endtask

    initial begin
        load_table();
        resetn      = 1'b0;
        flush       = 1'b0;
        in_valid    = 1'b0;
        id_to_ex    = '0;
        mem_allowin = 1'b0;
        mem_excep   = 1'b0;
        wb_excep    = 1'b0;
        idx         = 0;
        cur         = -1;
        cyc         = 0;
        offering    = 1'b0;
        kill_now    = 1'b0;
        held_ok     = 1'b0;
        held        = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        // sample a quarter period after driving, well before the next rising edge
        while (idx < tab.size() || cur >= 0) begin
            @(negedge clk);
            drive_cycle();
            #(PERIOD/4);
            check_outputs();
            advance();
        end
        $display("all %0d table entries done", tab.size());
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: hw/ex_top.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                flush,
    input  logic                in_valid,
    input  ex_pkg::id_to_ex_t   id_to_ex,
    output logic                ex_allowin,
    input  logic                mem_allowin,
    output logic                ex_to_mem_valid,
    output ex_pkg::ex_to_mem_t  ex_to_mem,
    output ex_pkg::ex_fwd_t     ex_fwd,
    input  logic                mem_excep,
    input  logic                wb_excep,
    output ex_pkg::sram_req_t   data_sram
);
    import ex_pkg::*;

    logic                alu_start;
    alu_op_e             alu_op;
    logic [`EX_XLEN-1:0] alu_src1;
    logic [`EX_XLEN-1:0] alu_src2;
    logic [`EX_XLEN-1:0] alu_result;   // also the memory address
    logic                alu_complete;
    logic                ex_valid;
    ls_size_e            ls_size;
    logic                mem_re;
    logic                mem_we;
    logic [`EX_XLEN-1:0] rkd_value;
    logic                ale;

    ex_stage u_stage (
        .clk             (clk),
        .resetn          (resetn),
        .flush           (flush),
        .in_valid        (in_valid),
        .id_to_ex        (id_to_ex),
        .ex_allowin      (ex_allowin),
        .mem_allowin     (mem_allowin),
        .ex_to_mem_valid (ex_to_mem_valid),
        .ex_to_mem       (ex_to_mem),
        .ex_fwd          (ex_fwd),
        .alu_start       (alu_start),
        .alu_op          (alu_op),
        .alu_src1        (alu_src1),
        .alu_src2        (alu_src2),
        .alu_result      (alu_result),
        .alu_complete    (alu_complete),
        .ex_valid        (ex_valid),
        .ls_size         (ls_size),
        .mem_re          (mem_re),
        .mem_we          (mem_we),
        .rkd_value       (rkd_value),
        .ale             (ale)
    );

    ex_alu u_alu (
        .clk      (clk),
        .resetn   (resetn),
        .start    (alu_start),
        .op       (alu_op),
        .src1     (alu_src1),
        .src2     (alu_src2),
        .abort    (flush),      // kill a running multiply
        .result   (alu_result),
        .complete (alu_complete)
    );

    ex_mem_req u_mem_req (
        .ex_valid  (ex_valid),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .ls_size   (ls_size),
        .rkd_value (rkd_value),
        .addr      (alu_result),
        .mem_excep (mem_excep),
        .wb_excep  (wb_excep),
        .data_sram (data_sram),
        .ale       (ale)
    );

endmodule

// File: hw/ex_mem_req.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_mem_req (
    input  logic                 ex_valid,
    input  logic                 mem_re,
    input  logic                 mem_we,
    input  ex_pkg::ls_size_e     ls_size,
    input  logic [`EX_XLEN-1:0]  rkd_value,
    input  logic [`EX_XLEN-1:0]  addr,
    input  logic                 mem_excep,
    input  logic                 wb_excep,
    output ex_pkg::sram_req_t    data_sram,
    output logic                 ale
);
    import ex_pkg::*;

    logic       access;
    logic [3:0] lane_mask;

    assign access = ex_valid & (mem_re | mem_we);

    // half must be even, word must be 4-aligned
    assign ale = access & (((ls_size == LS_H) & addr[0]) |
                           ((ls_size == LS_W) & (|addr[1:0])));

    always_comb begin
        case (ls_size)
            LS_B: begin
                lane_mask       = 4'b0001 << addr[1:0];
                data_sram.wdata = {4{rkd_value[7:0]}};
            end
            LS_H: begin
                lane_mask       = addr[1] ? 4'b1100 : 4'b0011;
                data_sram.wdata = {2{rkd_value[15:0]}};
            end
            default: begin
                lane_mask       = 4'b1111;
                data_sram.wdata = rkd_value;
            end
        endcase
    end

    // older exception in mem/wb cancels the access
    assign data_sram.en   = access & ~ale & ~mem_excep & ~wb_excep;
    assign data_sram.we   = (ex_valid & mem_we) ? lane_mask : 4'b0000;  // loads never write
    assign data_sram.addr = addr;

endmodule

// File: hw/ex_alu.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_alu (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 start,
    input  ex_pkg::alu_op_e      op,
    input  logic [`EX_XLEN-1:0]  src1,
    input  logic [`EX_XLEN-1:0]  src2,
    input  logic                 abort,
    output logic [`EX_XLEN-1:0]  result,
    output logic                 complete
);
    import ex_pkg::*;

    localparam int W   = `EX_XLEN;
    localparam int SHW = $clog2(`EX_XLEN);
    localparam int CW  = $clog2(`EX_MUL_ITER + 1);

    logic            is_mul;
    logic            mul_signed;
    logic [W-1:0]    abs1;
    logic [W-1:0]    abs2;
    logic [2*W-1:0]  mcand;      // shifted left each step
    logic [W-1:0]    mplier;     // shifted right each step
    logic [2*W-1:0]  acc;
    logic [2*W-1:0]  step_a;
    logic [W-1:0]    step_b;
    logic [2*W-1:0]  step_acc;
    logic [2*W-1:0]  prod;
    logic            neg;        // product sign fixup
    logic            busy;
    logic            done;
    logic [CW-1:0]   cnt;

    assign is_mul     = op inside {ALU_MUL, ALU_MULH, ALU_MULHU};
    assign mul_signed = (op == ALU_MULH);  // low word is sign agnostic
    assign abs1       = (mul_signed && src1[W-1]) ? -src1 : src1;
    assign abs2       = (mul_signed && src2[W-1]) ? -src2 : src2;

    // the start cycle already does the first step
    assign step_a   = start ? {{W{1'b0}}, abs1} : mcand;
    assign step_b   = start ? abs2 : mplier;
    assign step_acc = (start ? {2*W{1'b0}} : acc) + (step_b[0] ? step_a : {2*W{1'b0}});
    assign prod     = neg ? -acc : acc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (abort) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (start) begin
            busy <= is_mul;
            done <= 1'b0;
            cnt  <= CW'(`EX_MUL_ITER - 1);
        end else if (busy) begin
            cnt <= cnt - 1'b1;
            if (cnt == CW'(1)) begin  // last step
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || busy) begin
            acc    <= step_acc;
            mcand  <= step_a << 1;
            mplier <= step_b >> 1;
        end
        if (start) begin
            neg <= mul_signed & (src1[W-1] ^ src2[W-1]);
        end
    end

    always_comb begin
        case (op)
            ALU_ADD:   result = src1 + src2;
            ALU_SUB:   result = src1 - src2;
            ALU_SLT:   result = {{W-1{1'b0}}, $signed(src1) < $signed(src2)};
            ALU_SLTU:  result = {{W-1{1'b0}}, src1 < src2};
            ALU_AND:   result = src1 & src2;
            ALU_OR:    result = src1 | src2;
            ALU_NOR:   result = ~(src1 | src2);
            ALU_XOR:   result = src1 ^ src2;
            ALU_SLL:   result = src1 << src2[SHW-1:0];
            ALU_SRL:   result = src1 >> src2[SHW-1:0];
            ALU_SRA:   result = W'($signed(src1) >>> src2[SHW-1:0]);
            ALU_LUI:   result = src2;              // immediate already shifted
            ALU_MUL:   result = prod[W-1:0];
            ALU_MULH,
            ALU_MULHU: result = prod[2*W-1:W];
            default:   result = '0;
        endcase
    end

    // start cycle never reports the previous multiply
    assign complete = ~is_mul | (done & ~start);

    a_no_restart: assert property (@(posedge clk) disable iff (!resetn)
        start |-> !busy)
        else $error("alu started while multiplier busy");

    a_complete_hold: assert property (@(posedge clk) disable iff (!resetn)
        $fell(complete) |-> (start || $past(abort)))
        else $error("complete dropped without start or abort");

endmodule

// File: hw/ex_stage.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 flush,
    input  logic                 in_valid,
    input  ex_pkg::id_to_ex_t    id_to_ex,
    output logic                 ex_allowin,
    input  logic                 mem_allowin,
    output logic                 ex_to_mem_valid,
    output ex_pkg::ex_to_mem_t   ex_to_mem,
    output ex_pkg::ex_fwd_t      ex_fwd,
    output logic                 alu_start,
    output ex_pkg::alu_op_e      alu_op,
    output logic [`EX_XLEN-1:0]  alu_src1,
    output logic [`EX_XLEN-1:0]  alu_src2,
    input  logic [`EX_XLEN-1:0]  alu_result,
    input  logic                 alu_complete,
    output logic                 ex_valid,
    output ex_pkg::ls_size_e     ls_size,
    output logic                 mem_re,
    output logic                 mem_we,
    output logic [`EX_XLEN-1:0]  rkd_value,
    input  logic                 ale
);
    import ex_pkg::*;

    id_to_ex_t inst;       // latched instruction
    logic      first;      // set in the first EX cycle
    logic      accept;

    assign ex_allowin      = ~ex_valid | (alu_complete & mem_allowin);
    assign ex_to_mem_valid = ex_valid & alu_complete;
    assign accept          = in_valid & ex_allowin & ~flush;  // flush beats a new transfer

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (ex_allowin) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            first <= 1'b0;
        end else begin
            first <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst <= '0;
        end else if (accept) begin
            inst <= id_to_ex;
        end
    end

    assign alu_start = first;
    assign alu_op    = inst.alu_op;
    assign alu_src1  = inst.src1;
    assign alu_src2  = inst.src2;

    // memory request side
    assign ls_size   = inst.ls_size;
    assign mem_re    = inst.res_from_mem;
    assign mem_we    = inst.mem_we;
    assign rkd_value = inst.rkd_value;

    always_comb begin
        ex_to_mem.pc           = inst.pc;
        ex_to_mem.res_from_mem = inst.res_from_mem & ex_valid;
        ex_to_mem.rf_we        = inst.rf_we & ex_valid;
        ex_to_mem.rf_waddr     = inst.rf_waddr;
        ex_to_mem.alu_result   = alu_result;
        ex_to_mem.rkd_value    = inst.rkd_value;
        ex_to_mem.addr_lo      = alu_result[1:0];
        ex_to_mem.ls_size      = inst.ls_size;
        ex_to_mem.ls_unsigned  = inst.ls_unsigned;
        ex_to_mem.csr_re       = inst.csr_re;
        ex_to_mem.csr_we       = inst.csr_we;
        ex_to_mem.csr_num      = inst.csr_num;
        ex_to_mem.csr_wmask    = inst.csr_wmask;
        ex_to_mem.ertn         = inst.ertn;
        ex_to_mem.excep_en     = ale | inst.id_excep_en;
        ex_to_mem.ale          = ale;
        ex_to_mem.excep        = inst.excep;
    end

    always_comb begin
        ex_fwd.res_from_mem = inst.res_from_mem & ex_valid;
        ex_fwd.rf_we        = inst.rf_we & ex_valid;
        ex_fwd.rf_waddr     = inst.rf_waddr;
        ex_fwd.alu_result   = alu_result;
        ex_fwd.csr_re       = inst.csr_re & ex_valid;  // result only known in wb
    end

    // a stalled instruction must not change under the memory stage
    a_hold_stalled: assert property (@(posedge clk) disable iff (!resetn)
        ex_to_mem_valid && !mem_allowin && !flush |=> $stable(ex_to_mem))
        else $error("ex_to_mem changed while stalled");

    a_start_valid: assert property (@(posedge clk) disable iff (!resetn)
        alu_start |-> ex_valid)
        else $error("alu start with empty stage");

endmodule

// File: hw/ex_pkg.sv
`include "ex_cfg.svh"

package ex_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_MUL,        // low word of product
        ALU_MULH,       // high word, signed
        ALU_MULHU       // high word, unsigned
    } alu_op_e;

    typedef enum logic [1:0] {
        LS_B,
        LS_H,
        LS_W
    } ls_size_e;

    typedef struct packed {
        logic       adef;
        logic       syscall;
        logic       brk;
        logic       ine;
        logic [8:0] esubcode;
    } excep_t;

    // decoded instruction from decode
    typedef struct packed {
        logic [`EX_XLEN-1:0]   pc;
        alu_op_e               alu_op;
        logic [`EX_XLEN-1:0]   src1;
        logic [`EX_XLEN-1:0]   src2;
        logic [`EX_XLEN-1:0]   rkd_value;     // store data source
        logic                  res_from_mem;  // load
        logic                  mem_we;        // store
        logic                  rf_we;
        logic [`EX_RF_AW-1:0]  rf_waddr;
        ls_size_e              ls_size;
        logic                  ls_unsigned;
        logic                  csr_re;
        logic                  csr_we;
        logic [`EX_CSR_NW-1:0] csr_num;
        logic [`EX_XLEN-1:0]   csr_wmask;
        logic                  ertn;
        logic                  id_excep_en;
        excep_t                excep;
    } id_to_ex_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]   pc;
        logic                  res_from_mem;
        logic                  rf_we;
        logic [`EX_RF_AW-1:0]  rf_waddr;
        logic [`EX_XLEN-1:0]   alu_result;
        logic [`EX_XLEN-1:0]   rkd_value;
        logic [1:0]            addr_lo;       // for load data extraction
        ls_size_e              ls_size;
        logic                  ls_unsigned;
        logic                  csr_re;
        logic                  csr_we;
        logic [`EX_CSR_NW-1:0] csr_num;
        logic [`EX_XLEN-1:0]   csr_wmask;
        logic                  ertn;
        logic                  excep_en;
        logic                  ale;
        excep_t                excep;
    } ex_to_mem_t;

    // hazard/forward info back to decode
    typedef struct packed {
        logic                 res_from_mem;
        logic                 rf_we;
        logic [`EX_RF_AW-1:0] rf_waddr;
        logic [`EX_XLEN-1:0]  alu_result;
        logic                 csr_re;
    } ex_fwd_t;

    typedef struct packed {
        logic                   en;
        logic [`EX_XLEN/8-1:0]  we;
        logic [`EX_XLEN-1:0]    addr;
        logic [`EX_XLEN-1:0]    wdata;
    } sram_req_t;

endpackage

// File: hw/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// datapath width
`define EX_XLEN      32

// register file address width
`define EX_RF_AW     5

// CSR number width
`define EX_CSR_NW    14

// shift-add steps per multiply
`define EX_MUL_ITER  32

`endif
